// ==== fire2_pkg.sv ====
package fire2_pkg;

	//////////////////////////////////////////////////
	// Fixed-point widths
	//////////////////////////////////////////////////

	// Activation, weight and output word
	localparam int DATA_W = 16;
	// Accumulator and bias word
	localparam int ACC_W = 32;
	// Q2.14 fraction
	localparam int FRAC_BITS = 14;

	//////////////////////////////////////////////////
	// Layer geometry
	//////////////////////////////////////////////////

	// One MAC lane per output channel
	localparam int NUM_LANES = 4;
	localparam int KDIM = 3;
	localparam int CHIN = 2;
	// Taps per output pixel
	localparam int TAPS = KDIM * KDIM * CHIN;
	localparam int TAP_W = 5;
	// Output feature map side
	localparam int WOUT = 3;
	localparam int NUM_PIXELS = WOUT * WOUT;
	localparam int PIX_W = 4;

	//////////////////////////////////////////////////
	// Weight and bias contents
	//////////////////////////////////////////////////

	// Small integer weights spread over -32..31
	function automatic logic signed [DATA_W-1:0] weight_of(input int lane, input int tap);
		int raw;
		raw = ((lane * 7 + tap * 3) % 64) - 32;
		return DATA_W'(raw);
	endfunction

	// Bias sits at the product scale, Q4.28
	// Lanes 0 and 1 get a negative bias so ReLU is exercised
	function automatic logic signed [ACC_W-1:0] bias_of(input int lane);
		int raw;
		raw = (lane - 2) <<< (FRAC_BITS * 2);
		return ACC_W'(raw);
	endfunction

endpackage

// ==== weight_rom.sv ====
`timescale 1ns/1ps

module weight_rom (
	input  logic                                clk,
	input  logic        [fire2_pkg::TAP_W-1:0]  tap_addr,
	output logic signed [fire2_pkg::DATA_W-1:0] kernels [fire2_pkg::NUM_LANES]
);

	// Constant table, one row per tap
	logic signed [fire2_pkg::DATA_W-1:0] rom [fire2_pkg::TAPS][fire2_pkg::NUM_LANES];

	genvar t, l;
	generate
		for (t = 0; t < fire2_pkg::TAPS; t++) begin : g_tap
			for (l = 0; l < fire2_pkg::NUM_LANES; l++) begin : g_lane
				assign rom[t][l] = fire2_pkg::weight_of(l, t);
			end
		end
	endgenerate

	// Registered read, all lanes of one tap at once
	always_ff @(posedge clk) begin
		for (int i = 0; i < fire2_pkg::NUM_LANES; i++) begin
			kernels[i] <= rom[tap_addr][i];
		end
	end

	// Sequencer wraps before the top of the address space
	a_addr_range: assert property (
		@(posedge clk) int'(tap_addr) < fire2_pkg::TAPS
	) else $error("tap_addr %0d out of range", tap_addr);

endmodule

// ==== mac.sv ====
`timescale 1ns/1ps

module mac (
	input  logic                                clk,
	input  logic                                rst_n,
	input  logic                                en,
	input  logic                                clr,
	input  logic signed [fire2_pkg::DATA_W-1:0] pix,
	input  logic signed [fire2_pkg::DATA_W-1:0] ker,
	output logic signed [fire2_pkg::ACC_W-1:0]  acc_out
);

	// Running sum of the current pixel
	logic signed [fire2_pkg::ACC_W-1:0] acc;
	// Full precision product, Q4.28
	logic signed [fire2_pkg::ACC_W-1:0] prod;

	assign prod = pix * ker;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			acc     <= '0;
			acc_out <= '0;
		end else if (en) begin
			if (clr) begin
				// Last tap goes straight into the result
				acc_out <= acc + prod;
				// Next pixel starts from zero
				acc     <= '0;
			end else begin
				acc <= acc + prod;
			end
		end
		// Enable low holds everything
	end

endmodule

// ==== squeeze_sequencer.sv ====
`timescale 1ns/1ps

module squeeze_sequencer (
	input  logic                         clk,
	input  logic                         rst_n,
	input  logic                         en_d1,
	input  logic                         en_d2,
	output logic [fire2_pkg::TAP_W-1:0]  tap_addr,
	output logic                         clr,
	output logic                         sum_ready,
	output logic                         layer_done
);

	// Last tap seen on en_d1 and lined up with en_d2
	logic                        last_tap_d;
	// Finished pixels
	logic [fire2_pkg::PIX_W-1:0] pix_cnt;

	//////////////////////////////////////////////////
	// Tap address
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			tap_addr <= '0;
		end else if (en_d1) begin
			if (int'(tap_addr) == fire2_pkg::TAPS - 1)
				tap_addr <= '0;
			else
				tap_addr <= tap_addr + 1'b1;
		end
	end

	//////////////////////////////////////////////////
	// Clear pulse and sum ready
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			last_tap_d <= 1'b0;
			sum_ready  <= 1'b0;
		end else begin
			last_tap_d <= en_d1 && (int'(tap_addr) == fire2_pkg::TAPS - 1);
			// MAC result valid one cycle after clr
			sum_ready  <= clr;
		end
	end

	// Same cycle as the last product at the MAC inputs
	assign clr = last_tap_d && en_d2;

	//////////////////////////////////////////////////
	// Pixel count and layer end
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pix_cnt    <= '0;
			layer_done <= 1'b0;
		end else if (sum_ready && int'(pix_cnt) < fire2_pkg::NUM_PIXELS) begin
			pix_cnt <= pix_cnt + 1'b1;
			// Sticky once the last pixel is out
			if (int'(pix_cnt) == fire2_pkg::NUM_PIXELS - 1)
				layer_done <= 1'b1;
		end
	end

	// Last tap still enabled one stage later at the MACs
	a_last_tap_aligned: assert property (
		@(posedge clk) disable iff (!rst_n) last_tap_d |-> en_d2
	) else $error("last tap of a pixel lost before the MAC stage");

	// No finished pixel beyond the layer size
	a_pix_bound: assert property (
		@(posedge clk) disable iff (!rst_n)
			sum_ready |-> int'(pix_cnt) < fire2_pkg::NUM_PIXELS
	) else $error("pixel count %0d past layer size", pix_cnt);

endmodule

// ==== requant_relu.sv ====
`timescale 1ns/1ps

module requant_relu (
	input  logic                                clk,
	input  logic                                rst_n,
	input  logic                                capture,
	input  logic signed [fire2_pkg::ACC_W-1:0]  sums [fire2_pkg::NUM_LANES],
	output logic signed [fire2_pkg::DATA_W-1:0] ofm  [fire2_pkg::NUM_LANES]
);

	// Sum plus lane bias, still Q4.28
	logic signed [fire2_pkg::ACC_W-1:0] biased [fire2_pkg::NUM_LANES];

	always_comb begin
		for (int i = 0; i < fire2_pkg::NUM_LANES; i++) begin
			biased[i] = sums[i] + fire2_pkg::bias_of(i);
		end
	end

	// Q4.28 back to Q2.14, bits 30:29 dropped without saturation
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < fire2_pkg::NUM_LANES; i++) begin
				ofm[i] <= '0;
			end
		end else if (capture) begin
			for (int i = 0; i < fire2_pkg::NUM_LANES; i++) begin
				// ReLU
				if (biased[i][fire2_pkg::ACC_W-1])
					ofm[i] <= '0;
				else
					ofm[i] <= {biased[i][fire2_pkg::ACC_W-1],
						biased[i][fire2_pkg::FRAC_BITS+fire2_pkg::DATA_W-2:fire2_pkg::FRAC_BITS]};
			end
		end
	end

endmodule

// ==== fire2_squeeze.sv ====
`timescale 1ns/1ps

module fire2_squeeze (
	input  logic                                clk,
	input  logic                                rst_n,
	input  logic                                squeeze_en_i,
	input  logic signed [fire2_pkg::DATA_W-1:0] ifm_i,
	input  logic                                ram_feedback,
	output logic                                sample,
	output logic                                finish,
	output logic signed [fire2_pkg::DATA_W-1:0] ofm [fire2_pkg::NUM_LANES]
);

	// Input alignment stages
	logic                                en_d1;
	logic                                en_d2;
	logic signed [fire2_pkg::DATA_W-1:0] ifm_d1;
	logic signed [fire2_pkg::DATA_W-1:0] ifm_d2;

	// Sequencer outputs
	logic [fire2_pkg::TAP_W-1:0] tap_addr;
	logic                        clr;
	logic                        sum_ready;
	logic                        layer_done;

	// Per-lane weights and sums
	logic signed [fire2_pkg::DATA_W-1:0] kernels [fire2_pkg::NUM_LANES];
	logic signed [fire2_pkg::ACC_W-1:0]  sums    [fire2_pkg::NUM_LANES];

	// Sticky RAM feedback
	logic fb_latch;

	//////////////////////////////////////////////////
	// Input alignment
	//////////////////////////////////////////////////

	// Stage 1 drives the ROM address, stage 2 meets the ROM data
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			en_d1  <= 1'b0;
			en_d2  <= 1'b0;
			ifm_d1 <= '0;
			ifm_d2 <= '0;
		end else begin
			en_d1  <= squeeze_en_i;
			ifm_d1 <= ifm_i;
			en_d2  <= en_d1;
			ifm_d2 <= ifm_d1;
		end
	end

	//////////////////////////////////////////////////
	// Control and weights
	//////////////////////////////////////////////////

	squeeze_sequencer u_sequencer (
		.clk        (clk),
		.rst_n      (rst_n),
		.en_d1      (en_d1),
		.en_d2      (en_d2),
		.tap_addr   (tap_addr),
		.clr        (clr),
		.sum_ready  (sum_ready),
		.layer_done (layer_done)
	);

	weight_rom u_weight_rom (
		.clk      (clk),
		.tap_addr (tap_addr),
		.kernels  (kernels)
	);

	//////////////////////////////////////////////////
	// MAC lanes, shared activation
	//////////////////////////////////////////////////

	genvar k;
	generate
		for (k = 0; k < fire2_pkg::NUM_LANES; k++) begin : g_lane
			mac u_mac (
				.clk     (clk),
				.rst_n   (rst_n),
				.en      (en_d2),
				.clr     (clr),
				.pix     (ifm_d2),
				.ker     (kernels[k]),
				.acc_out (sums[k])
			);
		end
	endgenerate

	// Capture on sum_ready, one cycle after clr
	requant_relu u_requant (
		.clk     (clk),
		.rst_n   (rst_n),
		.capture (sum_ready),
		.sums    (sums),
		.ofm     (ofm)
	);

	//////////////////////////////////////////////////
	// Sample, feedback and finish
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			sample   <= 1'b0;
			fb_latch <= 1'b0;
		end else begin
			// ofm is updated on the same edge
			sample <= sum_ready;
			if (ram_feedback)
				fb_latch <= 1'b1;
		end
	end

	// Downstream RAM feedback overrides layer end
	assign finish = layer_done && !fb_latch;

endmodule

// ==== squeeze_checker.sv ====
`timescale 1ns/1ps

module squeeze_checker (
	input  logic                                clk,
	input  logic                                rst_n,
	input  logic                                squeeze_en_i,
	input  logic signed [fire2_pkg::DATA_W-1:0] ifm_i,
	input  logic                                ram_feedback,
	input  logic                                sample,
	input  logic                                finish,
	input  logic signed [fire2_pkg::DATA_W-1:0] ofm [fire2_pkg::NUM_LANES],
	input  logic                                run_done,
	output int                                  error_count,
	output int                                  check_count,
	output int                                  sample_count
);

	localparam int W = fire2_pkg::DATA_W;
	localparam int LANE_BITS = fire2_pkg::NUM_LANES * W;

	typedef logic [W-1:0] word_t;

	// Running lane sums of the pixel being fed
	longint acc [fire2_pkg::NUM_LANES];
	int tap_idx;
	// Finished pixels not yet sampled
	logic [LANE_BITS-1:0] exp_q [$];
	// Last sampled vector that ofm holds until the next sample
	logic [LANE_BITS-1:0] held;
	bit fb_seen;
	bit final_done;
	// Lanes without a negative bias that the data pushed below zero
	int relu_zeros;

	// Q4.28 to Q2.14 with ReLU and no wrap for in-range inputs
	function automatic word_t requant(input longint biased);
		longint q;
		if (biased < 0)
			return '0;
		q = (biased >>> fire2_pkg::FRAC_BITS) & 64'h7fff;
		return word_t'(q);
	endfunction

	//////////////////////////////////////////////////
	// Reference model with one tap per enabled cycle
	//////////////////////////////////////////////////

	task automatic take_tap();
		logic [LANE_BITS-1:0] vec;
		longint biased;
		for (int l = 0; l < fire2_pkg::NUM_LANES; l++) begin
			acc[l] += longint'(ifm_i) * longint'(fire2_pkg::weight_of(l, tap_idx));
		end
		tap_idx++;
		if (tap_idx == fire2_pkg::TAPS) begin
			for (int l = 0; l < fire2_pkg::NUM_LANES; l++) begin
				biased = acc[l] + longint'(fire2_pkg::bias_of(l));
				if (biased < 0 && fire2_pkg::bias_of(l) >= 0)
					relu_zeros++;
				vec[l*W +: W] = requant(biased);
				acc[l] = 0;
			end
			exp_q.push_back(vec);
			tap_idx = 0;
		end
	endtask

	//////////////////////////////////////////////////
	// Output comparison
	//////////////////////////////////////////////////

	task automatic check_outputs();
		bit finish_exp;
		// ofm changes on the same edge that raises sample
		if (sample) begin
			sample_count++;
			if (exp_q.size() == 0) begin
				error_count++;
				$display("Sample pulse at %0t with no finished pixel in the model", $time);
			end else begin
				held = exp_q.pop_front();
			end
		end
		for (int l = 0; l < fire2_pkg::NUM_LANES; l++) begin
			check_count++;
			if (ofm[l] !== held[l*W +: W]) begin
				error_count++;
				$display("[FAIL] %0t ofm[%0d] expected %h actual %h",
					$time, l, held[l*W +: W], ofm[l]);
			end
		end
		// Layer end unless feedback was seen on an earlier edge
		finish_exp = (sample_count >= fire2_pkg::NUM_PIXELS) && !fb_seen;
		check_count++;
		if (finish !== finish_exp) begin
			error_count++;
			$display("[FAIL] %0t finish expected %0b actual %0b", $time, finish_exp, finish);
		end
	endtask

	task automatic final_checks();
		if (sample_count != fire2_pkg::NUM_PIXELS) begin
			error_count++;
			$display("Saw %0d sample pulses instead of %0d", sample_count, fire2_pkg::NUM_PIXELS);
		end
		if (exp_q.size() != 0 || tap_idx != 0) begin
			error_count++;
			$display("Model holds %0d unsampled pixels and %0d loose taps", exp_q.size(), tap_idx);
		end
		if (relu_zeros == 0) begin
			error_count++;
			$display("No lane without a negative bias ever had a negative sum");
		end
	endtask

	always @(posedge clk) begin
		if (!rst_n) begin
			for (int l = 0; l < fire2_pkg::NUM_LANES; l++) begin
				acc[l] = 0;
			end
			tap_idx = 0;
			exp_q.delete();
			held = '0;
			fb_seen = 1'b0;
			final_done = 1'b0;
			relu_zeros = 0;
			error_count = 0;
			check_count = 0;
			sample_count = 0;
		end else begin
			check_outputs();
			if (squeeze_en_i)
				take_tap();
			// Feedback latched after the compare since the DUT takes it on this edge
			fb_seen = fb_seen | ram_feedback;
			if (run_done && !final_done) begin
				final_checks();
				final_done = 1'b1;
			end
		end
	end

endmodule

// ==== tb_fire2_squeeze.sv ====
`timescale 1ns/1ps

module tb_fire2_squeeze;

	// Stimulus length with margin
	localparam int TIMEOUT_CYCLES = fire2_pkg::NUM_PIXELS * fire2_pkg::TAPS * 4 + 100;

	typedef logic signed [fire2_pkg::DATA_W-1:0] act_t;

	logic clk;
	logic rst_n;
	logic squeeze_en_i;
	act_t ifm_i;
	logic ram_feedback;
	logic sample;
	logic finish;
	act_t ofm [fire2_pkg::NUM_LANES];
	logic run_done;
	int   error_count;
	int   check_count;
	int   sample_count;
	int   cycle_count;

	fire2_squeeze u_fire2_squeeze (
		.clk          (clk),
		.rst_n        (rst_n),
		.squeeze_en_i (squeeze_en_i),
		.ifm_i        (ifm_i),
		.ram_feedback (ram_feedback),
		.sample       (sample),
		.finish       (finish),
		.ofm          (ofm)
	);

	squeeze_checker u_checker (
		.clk          (clk),
		.rst_n        (rst_n),
		.squeeze_en_i (squeeze_en_i),
		.ifm_i        (ifm_i),
		.ram_feedback (ram_feedback),
		.sample       (sample),
		.finish       (finish),
		.ofm          (ofm),
		.run_done     (run_done),
		.error_count  (error_count),
		.check_count  (check_count),
		.sample_count (sample_count)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	//////////////////////////////////////////////////
	// Stimulus helpers
	//////////////////////////////////////////////////

	// Plus or minus 1/8 in Q2.14
	function automatic act_t rand_act();
		int v;
		v = int'($urandom_range(4096)) - 2048;
		return act_t'(v);
	endfunction

	// Random magnitude, sign chosen by caller
	function automatic act_t signed_act(input bit negative);
		int v;
		v = int'($urandom_range(2048, 1));
		if (negative)
			v = -v;
		return act_t'(v);
	endfunction

	// Enable high three cycles in four, junk data in the gaps
	task automatic send_tap(input act_t val);
		bit sent;
		sent = 1'b0;
		while (!sent) begin
			@(negedge clk);
			if ($urandom_range(3) != 0) begin
				squeeze_en_i = 1'b1;
				ifm_i = val;
				sent = 1'b1;
			end else begin
				squeeze_en_i = 1'b0;
				ifm_i = rand_act();
			end
		end
	endtask

	task automatic idle(input int n);
		repeat (n) begin
			@(negedge clk);
			squeeze_en_i = 1'b0;
			ifm_i = rand_act();
		end
	endtask

	task automatic send_pixel(input int pix);
		for (int t = 0; t < fire2_pkg::TAPS; t++) begin
			// Long stalls in the middle of two pixels
			if ((pix == 6 && t == 9) || (pix == 7 && t == 13))
				idle(30);
			// Pixels 3 to 5 alternate sign tap by tap
			if (pix >= 3 && pix <= 5)
				send_tap(signed_act(t % 2 == 1));
			else
				send_tap(rand_act());
		end
	endtask

	//////////////////////////////////////////////////
	// Main sequence
	//////////////////////////////////////////////////

	initial begin
		rst_n = 1'b0;
		squeeze_en_i = 1'b0;
		ifm_i = '0;
		ram_feedback = 1'b0;
		run_done = 1'b0;
		void'($urandom(32'he9fa));
		repeat (8) @(negedge clk);
		rst_n = 1'b1;
		idle(3);
		for (int p = 0; p < fire2_pkg::NUM_PIXELS; p++) begin
			send_pixel(p);
		end
		idle(1);
		// Layer end, bounded by the timeout below
		while (!finish) @(negedge clk);
		idle(10);
		// Single-cycle RAM feedback pulse
		@(negedge clk);
		ram_feedback = 1'b1;
		@(negedge clk);
		ram_feedback = 1'b0;
		idle(10);
		run_done = 1'b1;
		repeat (2) @(negedge clk);
		$display("Checks %0d, errors %0d, samples %0d", check_count, error_count, sample_count);
		if (error_count == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

	initial begin
		cycle_count = 0;
		while (cycle_count < TIMEOUT_CYCLES) begin
			@(posedge clk);
			cycle_count++;
		end
		$display("Run stopped after %0d cycles without completing", cycle_count);
		$display("Test failures found");
		$finish;
	end

endmodule

// ==== build.f ====
fire2_pkg.sv
weight_rom.sv
mac.sv
squeeze_sequencer.sv
requant_relu.sv
fire2_squeeze.sv
squeeze_checker.sv
tb_fire2_squeeze.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = tb_fire2_squeeze
FILELIST = build.f
OBJ_DIR  = obj_dir
LOG      = sim.log
FAIL_MSG = Test failures found
PASS_MSG = All tests passed!

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, search the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed, see $(LOG)"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation ended early, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
